// File: Makefile
# Verilator simulation of the SoC testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_soc -o vsim
	@out=$$(./obj_dir/vsim +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: files.f
hdl/soc_pkg.sv
hdl/bus_arbiter.sv
hdl/addr_decoder.sv
hdl/boot_rom.sv
hdl/main_sram.sv
hdl/clint.sv
hdl/debug_gate.sv
hdl/soc_top.sv
testbench/soc_props.sv
testbench/tb_soc.sv

// File: hdl/addr_decoder.sv
// ----------------------------------------------------------
// Address decode of the shared bus onto ROM, SRAM and CLINT
// Every request is accepted at once, the response comes one
// cycle later. ROM writes and unmapped accesses strobe no
// target and answer with err set and rdata zero
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module addr_decoder (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              bus_req_i,
  input  soc_pkg::bus_req_t bus_i,
  output logic              bus_rvalid_o,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  output logic              rom_req_o,
  output logic              sram_req_o,
  output logic              clint_req_o,
  output soc_pkg::bus_req_t tgt_o,
  input  soc_pkg::bus_rsp_t rom_rsp_i,
  input  soc_pkg::bus_rsp_t sram_rsp_i,
  input  soc_pkg::bus_rsp_t clint_rsp_i
);

  soc_pkg::target_e sel;
  soc_pkg::target_e sel_q;
  logic             valid_q;

  // Offset compare, addresses below a base wrap to large values
  always_comb begin
    sel = soc_pkg::TGT_NONE;
    if ((bus_i.addr - soc_pkg::RomBase) < soc_pkg::RomWords * soc_pkg::BeWidth) begin
      if (!bus_i.we) begin
        sel = soc_pkg::TGT_ROM;
      end
    end else if ((bus_i.addr - soc_pkg::SramBase) < soc_pkg::SramWords * soc_pkg::BeWidth) begin
      sel = soc_pkg::TGT_SRAM;
    end else if ((bus_i.addr - soc_pkg::ClintBase) < soc_pkg::ClintLength) begin
      sel = soc_pkg::TGT_CLINT;
    end
  end

  assign rom_req_o   = bus_req_i && (sel == soc_pkg::TGT_ROM);
  assign sram_req_o  = bus_req_i && (sel == soc_pkg::TGT_SRAM);
  assign clint_req_o = bus_req_i && (sel == soc_pkg::TGT_CLINT);
  assign tgt_o       = bus_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      sel_q   <= soc_pkg::TGT_NONE;
    end else begin
      valid_q <= bus_req_i;
      sel_q   <= sel;
    end
  end

  assign bus_rvalid_o = valid_q;

  always_comb begin
    case (sel_q)
      soc_pkg::TGT_ROM:   bus_rsp_o = rom_rsp_i;
      soc_pkg::TGT_SRAM:  bus_rsp_o = sram_rsp_i;
      soc_pkg::TGT_CLINT: bus_rsp_o = clint_rsp_i;
      default: begin
        bus_rsp_o.rdata = '0;
        bus_rsp_o.err   = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/boot_rom.sv
// ----------------------------------------------------------
// Boot image as a generated pattern, read only
// Word i holds RomTag|i in the upper half and its inverse
// in the lower half. Read data is valid one cycle after req
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
  input  logic                                 clk_i,
  input  logic                                 req_i,
  input  logic [$clog2(soc_pkg::RomWords)-1:0] addr_i,
  output logic [soc_pkg::DataWidth-1:0]        rdata_o
);

  logic [31:0] word_hi;

  assign word_hi = soc_pkg::RomTag | 32'(addr_i);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= {word_hi, ~word_hi};
    end
  end

endmodule

`default_nettype wire

// File: hdl/bus_arbiter.sv
// ----------------------------------------------------------
// Round-robin arbiter of the hart ports onto one shared bus
// Grant is combinational from req, rvalid follows one cycle
// after grant and goes back to the granted hart only
// A hart must hold req and payload until it sees gnt
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic              [soc_pkg::NumHarts-1:0]     hart_req_i,
  input  soc_pkg::bus_req_t [soc_pkg::NumHarts-1:0]     hart_bus_i,
  output logic              [soc_pkg::NumHarts-1:0]     hart_gnt_o,
  output logic              [soc_pkg::NumHarts-1:0]     hart_rvalid_o,
  output soc_pkg::bus_rsp_t [soc_pkg::NumHarts-1:0]     hart_rsp_o,
  output logic                                          bus_req_o,
  output soc_pkg::bus_req_t                             bus_o,
  input  logic                                          bus_rvalid_i,
  input  soc_pkg::bus_rsp_t                             bus_rsp_i
);

  logic [soc_pkg::HartIdxWidth-1:0] last_q;
  logic [soc_pkg::HartIdxWidth-1:0] rsp_idx_q;
  logic [soc_pkg::HartIdxWidth-1:0] gnt_idx;
  logic                             gnt_any;

  // Search starts at the hart after the last winner
  always_comb begin
    int unsigned cand;
    gnt_any = 1'b0;
    gnt_idx = last_q;
    for (int unsigned i = 1; i <= soc_pkg::NumHarts; i++) begin
      cand = (int'(last_q) + i) % soc_pkg::NumHarts;
      if (!gnt_any && hart_req_i[cand]) begin
        gnt_any = 1'b1;
        gnt_idx = cand[soc_pkg::HartIdxWidth-1:0];
      end
    end
  end

  assign bus_req_o = gnt_any;
  assign bus_o     = hart_bus_i[gnt_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q    <= '0;
      rsp_idx_q <= '0;
    end else if (gnt_any) begin
      last_q    <= gnt_idx;
      rsp_idx_q <= gnt_idx;
    end
  end

  // Response goes to the hart granted in the previous cycle
  always_comb begin
    for (int h = 0; h < soc_pkg::NumHarts; h++) begin
      hart_gnt_o[h]    = gnt_any && (gnt_idx == h);
      hart_rvalid_o[h] = bus_rvalid_i && (rsp_idx_q == h);
      hart_rsp_o[h]    = (rsp_idx_q == h) ? bus_rsp_i : '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/clint.sv
// ----------------------------------------------------------
// Core-local interruptor with mtime, mtimecmp and msip
// mtime counts rising edges of rtc_i after a two-flop sync
// and is read only. Writes always update the full word
// Unknown offsets read as zero
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module clint (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rtc_i,
  input  logic                          req_i,
  input  soc_pkg::bus_req_t             tgt_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic [soc_pkg::NumHarts-1:0]  timer_irq_o,
  output logic [soc_pkg::NumHarts-1:0]  ipi_o
);

  logic [2:0]                                               rtc_q;
  logic                                                     rtc_rise;
  logic [soc_pkg::DataWidth-1:0]                            mtime_q;
  logic [soc_pkg::NumHarts-1:0][soc_pkg::DataWidth-1:0]     mtimecmp_q;
  logic [soc_pkg::NumHarts-1:0]                             msip_q;
  logic [$clog2(soc_pkg::ClintLength)-1:0]                  off;
  logic [soc_pkg::DataWidth-1:0]                            rd_data;

  assign off = tgt_i.addr[$clog2(soc_pkg::ClintLength)-1:0];

  // Two sync stages, the third flop finds the edge
  assign rtc_rise = rtc_q[1] && !rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_i && tgt_i.we) begin
        for (int h = 0; h < soc_pkg::NumHarts; h++) begin
          if (off == soc_pkg::MsipOffset + 8 * h) begin
            msip_q[h] <= tgt_i.wdata[0];
          end
          if (off == soc_pkg::MtimecmpOffset + 8 * h) begin
            mtimecmp_q[h] <= tgt_i.wdata;
          end
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (off == soc_pkg::MtimeOffset) begin
      rd_data = mtime_q;
    end
    for (int h = 0; h < soc_pkg::NumHarts; h++) begin
      if (off == soc_pkg::MsipOffset + 8 * h) begin
        rd_data = {{(soc_pkg::DataWidth-1){1'b0}}, msip_q[h]};
      end
      if (off == soc_pkg::MtimecmpOffset + 8 * h) begin
        rd_data = mtimecmp_q[h];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_data;
    end
  end

  always_comb begin
    for (int h = 0; h < soc_pkg::NumHarts; h++) begin
      timer_irq_o[h] = (mtime_q >= mtimecmp_q[h]);
    end
  end

  assign ipi_o = msip_q;

endmodule

`default_nettype wire

// File: hdl/debug_gate.sv
// ----------------------------------------------------------
// Debug request gate for hart 0
// The request is blocked for DebugDelayCycles cycles after
// reset so the hart can run its boot code first
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  logic [soc_pkg::DebugCntWidth-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) && debug_req_i && debug_en_i;

endmodule

`default_nettype wire

// File: hdl/main_sram.sv
// ----------------------------------------------------------
// Main memory, one 64-bit word per address
// Writes honour the byte enables, a write returns the old
// word. Contents are undefined after power up
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module main_sram (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  soc_pkg::bus_req_t             tgt_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);

  logic [soc_pkg::DataWidth-1:0]         mem_q [soc_pkg::SramWords];
  logic [$clog2(soc_pkg::SramWords)-1:0] idx;

  // Drop the byte offset within the word
  assign idx = tgt_i.addr[$clog2(soc_pkg::BeWidth) +: $clog2(soc_pkg::SramWords)];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (tgt_i.we) begin
        for (int b = 0; b < soc_pkg::BeWidth; b++) begin
          if (tgt_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= tgt_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_o <= mem_q[idx];
    end
  end

endmodule

`default_nettype wire

// File: hdl/soc_pkg.sv
// ----------------------------------------------------------
// Shared widths, address map and bus types of the SoC
// Targets are word addressed with 64-bit words
// CLINT offsets are relative to ClintBase
// ----------------------------------------------------------
`default_nettype none

package soc_pkg;

  localparam int unsigned NumHarts     = 2;
  localparam int unsigned HartIdxWidth = $clog2(NumHarts);

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam int unsigned          RomWords    = 512;
  localparam logic [AddrWidth-1:0] SramBase    = 32'h8000_0000;
  localparam int unsigned          SramWords   = 2048;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam int unsigned          ClintLength = 32'h0000_C000;

  // CLINT register offsets, 8 bytes apart per hart
  localparam int unsigned MsipOffset     = 32'h0000;
  localparam int unsigned MtimecmpOffset = 32'h4000;
  localparam int unsigned MtimeOffset    = 32'hBFF8;

  localparam logic [31:0] RomTag = 32'hB007_0000;

  localparam int unsigned DebugDelayCycles = 500;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: hdl/soc_top.sv
// ----------------------------------------------------------
// Memory side of a two-hart SoC
// Hart ports share one bus through a round-robin arbiter
// The cores live outside, one reset for the whole design
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      rtc_i,
  input  logic              [soc_pkg::NumHarts-1:0] hart_req_i,
  input  soc_pkg::bus_req_t [soc_pkg::NumHarts-1:0] hart_bus_i,
  input  logic                                      debug_req_i,
  input  logic                                      debug_en_i,
  output logic              [soc_pkg::NumHarts-1:0] hart_gnt_o,
  output logic              [soc_pkg::NumHarts-1:0] hart_rvalid_o,
  output soc_pkg::bus_rsp_t [soc_pkg::NumHarts-1:0] hart_rsp_o,
  output logic              [soc_pkg::NumHarts-1:0] timer_irq_o,
  output logic              [soc_pkg::NumHarts-1:0] ipi_o,
  output logic                                      debug_req_o
);

  logic              bus_req;
  soc_pkg::bus_req_t bus;
  logic              bus_rvalid;
  soc_pkg::bus_rsp_t bus_rsp;

  logic              rom_req;
  logic              sram_req;
  logic              clint_req;
  soc_pkg::bus_req_t tgt;
  soc_pkg::bus_rsp_t rom_rsp;
  soc_pkg::bus_rsp_t sram_rsp;
  soc_pkg::bus_rsp_t clint_rsp;

  // Targets never flag errors themselves
  assign rom_rsp.err   = 1'b0;
  assign sram_rsp.err  = 1'b0;
  assign clint_rsp.err = 1'b0;

  bus_arbiter i_bus_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .hart_req_i    ( hart_req_i    ),
    .hart_bus_i    ( hart_bus_i    ),
    .hart_gnt_o    ( hart_gnt_o    ),
    .hart_rvalid_o ( hart_rvalid_o ),
    .hart_rsp_o    ( hart_rsp_o    ),
    .bus_req_o     ( bus_req       ),
    .bus_o         ( bus           ),
    .bus_rvalid_i  ( bus_rvalid    ),
    .bus_rsp_i     ( bus_rsp       )
  );

  addr_decoder i_addr_decoder (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bus_req_i    ( bus_req    ),
    .bus_i        ( bus        ),
    .bus_rvalid_o ( bus_rvalid ),
    .bus_rsp_o    ( bus_rsp    ),
    .rom_req_o    ( rom_req    ),
    .sram_req_o   ( sram_req   ),
    .clint_req_o  ( clint_req  ),
    .tgt_o        ( tgt        ),
    .rom_rsp_i    ( rom_rsp    ),
    .sram_rsp_i   ( sram_rsp   ),
    .clint_rsp_i  ( clint_rsp  )
  );

  // ROM base is aligned past the image size, low bits index directly
  boot_rom i_boot_rom (
    .clk_i   ( clk_i                                                                     ),
    .req_i   ( rom_req                                                                   ),
    .addr_i  ( tgt.addr[$clog2(soc_pkg::BeWidth) +: $clog2(soc_pkg::RomWords)]          ),
    .rdata_o ( rom_rsp.rdata                                                             )
  );

  main_sram i_main_sram (
    .clk_i   ( clk_i          ),
    .req_i   ( sram_req       ),
    .tgt_i   ( tgt            ),
    .rdata_o ( sram_rsp.rdata )
  );

  clint i_clint (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .rtc_i       ( rtc_i           ),
    .req_i       ( clint_req       ),
    .tgt_i       ( tgt             ),
    .rdata_o     ( clint_rsp.rdata ),
    .timer_irq_o ( timer_irq_o     ),
    .ipi_o       ( ipi_o           )
  );

  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

// File: testbench/soc_props.sv
// ----------------------------------------------------------
// Bus timing, interrupt and debug window properties of soc_top
// Timer check uses mtime and mtimecmp as read back on the ports
// mtimecmp counts as known only after a read with no write since
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_props (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic              [soc_pkg::NumHarts-1:0] req_i,
  input soc_pkg::bus_req_t [soc_pkg::NumHarts-1:0] bus_i,
  input logic              [soc_pkg::NumHarts-1:0] gnt_i,
  input logic              [soc_pkg::NumHarts-1:0] rvalid_i,
  input soc_pkg::bus_rsp_t [soc_pkg::NumHarts-1:0] rsp_i,
  input logic              [soc_pkg::NumHarts-1:0] timer_irq_i,
  input logic                                      debug_req_i
);

  int unsigned fail_cnt = 0;
  int unsigned cyc_q;

  // Pending reads per port, cmp_rd_q is indexed [port][hart]
  logic [soc_pkg::NumHarts-1:0]                         mtime_rd_q;
  logic [soc_pkg::NumHarts-1:0][soc_pkg::NumHarts-1:0]  cmp_rd_q;
  logic [soc_pkg::NumHarts-1:0][soc_pkg::DataWidth-1:0] cmp_q;
  logic [soc_pkg::NumHarts-1:0]                         cmp_known_q;
  logic [soc_pkg::NumHarts-1:0]                         irq_q;

  function automatic logic clint_hit(input soc_pkg::bus_req_t req, input int unsigned offset);
    return req.addr == soc_pkg::ClintBase + offset;
  endfunction

  // Cycles since reset, saturating at the end of the debug window
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_q <= 0;
    end else if (cyc_q < soc_pkg::DebugDelayCycles) begin
      cyc_q <= cyc_q + 1;
    end
  end

  // Interrupt state at the grant edge matches the mtime the CLINT registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_rd_q  <= '0;
      cmp_rd_q    <= '0;
      cmp_q       <= '0;
      cmp_known_q <= '0;
      irq_q       <= '0;
    end else begin
      irq_q <= timer_irq_i;
      for (int p = 0; p < soc_pkg::NumHarts; p++) begin
        mtime_rd_q[p] <= gnt_i[p] && !bus_i[p].we && clint_hit(bus_i[p], soc_pkg::MtimeOffset);
        for (int h = 0; h < soc_pkg::NumHarts; h++) begin
          cmp_rd_q[p][h] <= gnt_i[p] && !bus_i[p].we &&
                            clint_hit(bus_i[p], soc_pkg::MtimecmpOffset + 8 * h);
          if (rvalid_i[p] && cmp_rd_q[p][h]) begin
            cmp_q[h]       <= rsp_i[p].rdata;
            cmp_known_q[h] <= 1'b1;
          end
          if (gnt_i[p] && bus_i[p].we && clint_hit(bus_i[p], soc_pkg::MtimecmpOffset + 8 * h)) begin
            cmp_known_q[h] <= 1'b0;
          end
        end
      end
    end
  end

  one_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_i))
    else begin
      fail_cnt++;
      $error("more than one grant in one cycle");
    end

  debug_window_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cyc_q < soc_pkg::DebugDelayCycles) |-> !debug_req_i)
    else begin
      fail_cnt++;
      $error("debug request passed during the delay window");
    end

  for (genvar h = 0; h < soc_pkg::NumHarts; h++) begin : g_hart
    gnt_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i[h] |-> req_i[h])
      else begin
        fail_cnt++;
        $error("grant to hart %0d without a request", h);
      end
    gnt_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i[h] |=> rvalid_i[h])
      else begin
        fail_cnt++;
        $error("no rvalid one cycle after grant on hart %0d", h);
      end
    rvalid_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rvalid_i[h] |-> $past(gnt_i[h]))
      else begin
        fail_cnt++;
        $error("rvalid on hart %0d without a grant the cycle before", h);
      end
    for (genvar p = 0; p < soc_pkg::NumHarts; p++) begin : g_port
      timer_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rvalid_i[p] && mtime_rd_q[p] && cmp_known_q[h]) |->
          (irq_q[h] == (rsp_i[p].rdata >= cmp_q[h])))
        else begin
          fail_cnt++;
          $error("timer interrupt of hart %0d does not match mtime and mtimecmp read back", h);
        end
    end
  end

endmodule

bind soc_top soc_props i_soc_props (
  .clk_i       ( clk_i         ),
  .rst_ni      ( rst_ni        ),
  .req_i       ( hart_req_i    ),
  .bus_i       ( hart_bus_i    ),
  .gnt_i       ( hart_gnt_o    ),
  .rvalid_i    ( hart_rvalid_o ),
  .rsp_i       ( hart_rsp_o    ),
  .timer_irq_i ( timer_irq_o   ),
  .debug_req_i ( debug_req_o   )
);

`default_nettype wire

// File: testbench/tb_soc.sv
// ----------------------------------------------------------
// Testbench of the SoC memory side with two hart ports
// Ports are driven 2 ns after the rising edge and sampled on
// the falling edge. SRAM words are read back only after a
// full-word write
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_soc;

  localparam int unsigned TestCycles = soc_pkg::DebugDelayCycles + 100;
  localparam int unsigned GntTimeout = 8;
  localparam int unsigned SharedWord = 20;

  logic                                      clk = 1'b0;
  logic                                      rst_n;
  logic                                      rtc;
  logic              [soc_pkg::NumHarts-1:0] hart_req;
  soc_pkg::bus_req_t [soc_pkg::NumHarts-1:0] hart_bus;
  logic                                      debug_req;
  logic                                      debug_en;
  logic              [soc_pkg::NumHarts-1:0] hart_gnt;
  logic              [soc_pkg::NumHarts-1:0] hart_rvalid;
  soc_pkg::bus_rsp_t [soc_pkg::NumHarts-1:0] hart_rsp;
  logic              [soc_pkg::NumHarts-1:0] timer_irq;
  logic              [soc_pkg::NumHarts-1:0] ipi;
  logic                                      debug_out;

  integer      seed = 32'h9ede7721;
  int unsigned errors = 0;
  int unsigned cycle = 0;
  int          last_gnt = -1;
  logic [63:0] sram_model [int];

  soc_top soc_top_i (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .rtc_i         ( rtc         ),
    .hart_req_i    ( hart_req    ),
    .hart_bus_i    ( hart_bus    ),
    .debug_req_i   ( debug_req   ),
    .debug_en_i    ( debug_en    ),
    .hart_gnt_o    ( hart_gnt    ),
    .hart_rvalid_o ( hart_rvalid ),
    .hart_rsp_o    ( hart_rsp    ),
    .timer_irq_o   ( timer_irq   ),
    .ipi_o         ( ipi         ),
    .debug_req_o   ( debug_out   )
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n) begin
      cycle <= cycle + 1;
    end
  end

  // With both harts requesting, the last winner has to yield
  always @(negedge clk) begin
    if (rst_n && (hart_gnt != '0)) begin
      if ((&hart_req) && (last_gnt >= 0)) begin
        assert (!hart_gnt[last_gnt]) else begin
          errors++;
          $display("error arbitration: expected hart %0d, actual gnt %b", 1 - last_gnt, hart_gnt);
        end
      end
      last_gnt = hart_gnt[1] ? 1 : 0;
    end
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // Upper half RomTag|index, lower half its inverse
  function automatic logic [63:0] rom_word(input int unsigned index);
    logic [31:0] hi;
    hi = soc_pkg::RomTag | index;
    return {hi, ~hi};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wdata,
                                              input logic [7:0] be);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old & ~mask) | (wdata & mask);
  endfunction

  // One access on port h: request, wait for gnt, then rvalid
  task automatic bus_access(input int h, input logic we, input logic [31:0] addr,
                            input logic [7:0] be, input logic [63:0] wdata,
                            output logic [63:0] rdata, output logic err,
                            output logic [63:0] model_rd);
    int unsigned waited;
    int          idx;
    waited   = 0;
    rdata    = '0;
    err      = 1'b1;
    model_rd = 64'bx;
    idx      = int'((addr - soc_pkg::SramBase) >> 3);
    @(posedge clk);
    #2;
    hart_req[h] = 1'b1;
    hart_bus[h] = '{we: we, addr: addr, be: be, wdata: wdata};
    @(negedge clk);
    while (!hart_gnt[h] && waited < GntTimeout) begin
      waited++;
      @(negedge clk);
    end
    if (!hart_gnt[h]) begin
      errors++;
      $display("Hart %0d was not granted within %0d cycles", h, GntTimeout);
      hart_req[h] = 1'b0;
    end else begin
      // SRAM model follows the order of grants
      if (addr - soc_pkg::SramBase < soc_pkg::SramWords * 8) begin
        if (we) begin
          sram_model[idx] = merge_bytes(sram_model.exists(idx) ? sram_model[idx] : 64'bx,
                                        wdata, be);
        end else if (sram_model.exists(idx)) begin
          model_rd = sram_model[idx];
        end
      end
      @(posedge clk);
      #2;
      hart_req[h] = 1'b0;
      @(negedge clk);
      if (!hart_rvalid[h]) begin
        errors++;
        $display("Hart %0d got no response one cycle after its grant", h);
      end
      rdata = hart_rsp[h].rdata;
      err   = hart_rsp[h].err;
    end
  endtask

  task automatic sram_run(input int h, input int first);
    logic [63:0] rd;
    logic [63:0] exp;
    logic        err;
    logic [31:0] addr;
    for (int w = 0; w < 4; w++) begin
      addr = soc_pkg::SramBase + 32'(8 * (first + w));
      bus_access(h, 1'b1, addr, 8'hFF, rand64(), rd, err, exp);
      bus_access(h, 1'b1, addr, 8'($random(seed)), rand64(), rd, err, exp);
      check_val($sformatf("sram write err hart %0d", h), 64'd0, 64'(err));
      bus_access(h, 1'b0, addr, 8'h00, '0, rd, err, exp);
      check_val($sformatf("sram hart %0d word %0d", h, first + w), exp, rd);
      check_val($sformatf("sram read err hart %0d", h), 64'd0, 64'(err));
    end
  endtask

  task automatic rom_run();
    int          idx [5] = '{0, 1, 7, 300, 511};
    logic [63:0] rd;
    logic [63:0] exp;
    logic        err;
    foreach (idx[n]) begin
      bus_access(0, 1'b0, soc_pkg::RomBase + 32'(8 * idx[n]), 8'h00, '0, rd, err, exp);
      check_val($sformatf("rom word %0d", idx[n]), rom_word(idx[n]), rd);
      check_val($sformatf("rom word %0d err", idx[n]), 64'd0, 64'(err));
    end
    bus_access(0, 1'b1, soc_pkg::RomBase + 56, 8'hFF, rand64(), rd, err, exp);
    check_val("rom write err", 64'd1, 64'(err));
    check_val("rom write rdata", 64'd0, rd);
    bus_access(0, 1'b0, soc_pkg::RomBase + 56, 8'h00, '0, rd, err, exp);
    check_val("rom word 7 after write", rom_word(7), rd);
  endtask

  // Old GPIO hole and the first address past the CLINT
  task automatic unmapped_run();
    logic [31:0] addrs [3] = '{32'h4000_0000, 32'h4000_0008, 32'h0200_C000};
    logic [63:0] rd;
    logic [63:0] exp;
    logic        err;
    foreach (addrs[n]) begin
      bus_access(1, (n == 1), addrs[n], 8'hFF, rand64(), rd, err, exp);
      check_val($sformatf("unmapped %h rdata", addrs[n]), 64'd0, rd);
      check_val($sformatf("unmapped %h err", addrs[n]), 64'd1, 64'(err));
    end
  endtask

  // Hart 1 idles one extra cycle so the requests keep colliding
  task automatic contention_run(input int h);
    logic [63:0] rd;
    logic [63:0] exp;
    logic        err;
    for (int n = 0; n < 4; n++) begin
      bus_access(h, 1'b1, soc_pkg::SramBase + 8 * SharedWord, 8'hFF, rand64(), rd, err, exp);
      bus_access(h, 1'b0, soc_pkg::SramBase + 64 * h, 8'h00, '0, rd, err, exp);
      check_val($sformatf("contention read hart %0d", h), exp, rd);
      repeat (h) @(posedge clk);
    end
  endtask

  task automatic rtc_pulse();
    @(posedge clk);
    #2;
    rtc = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rtc = 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic clint_run();
    logic [63:0] rd;
    logic [63:0] exp;
    logic [63:0] t0;
    logic        err;
    bus_access(0, 1'b1, soc_pkg::ClintBase + soc_pkg::MsipOffset + 8, 8'hFF, 64'd1, rd, err, exp);
    check_val("msip hart 1 set", 64'b10, 64'(ipi));
    bus_access(0, 1'b1, soc_pkg::ClintBase + soc_pkg::MsipOffset + 8, 8'hFF, 64'd0, rd, err, exp);
    check_val("msip hart 1 clear", 64'b00, 64'(ipi));
    bus_access(0, 1'b0, soc_pkg::ClintBase + soc_pkg::MtimeOffset, 8'h00, '0, t0, err, exp);
    bus_access(0, 1'b1, soc_pkg::ClintBase + soc_pkg::MtimecmpOffset, 8'hFF, t0 + 3, rd, err, exp);
    bus_access(0, 1'b0, soc_pkg::ClintBase + soc_pkg::MtimecmpOffset, 8'h00, '0, rd, err, exp);
    check_val("mtimecmp hart 0 readback", t0 + 3, rd);
    for (int p = 1; p <= 3; p++) begin
      rtc_pulse();
      bus_access(0, 1'b0, soc_pkg::ClintBase + soc_pkg::MtimeOffset, 8'h00, '0, rd, err, exp);
      check_val($sformatf("mtime after pulse %0d", p), t0 + p, rd);
      check_val($sformatf("timer irq after pulse %0d", p), (p >= 3) ? 64'b01 : 64'b00,
                64'(timer_irq));
    end
  endtask

  task automatic debug_step(input logic req, input logic en, input string name);
    @(posedge clk);
    #2;
    debug_req = req;
    debug_en  = en;
    @(negedge clk);
    check_val(name, 64'(req & en), 64'(debug_out));
  endtask

  initial begin
    logic [63:0] rd;
    logic [63:0] exp;
    logic        err;
    rst_n     = 1'b0;
    rtc       = 1'b0;
    hart_req  = '0;
    hart_bus  = '0;
    debug_req = 1'b1;
    debug_en  = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fork
      sram_run(0, 0);
      sram_run(1, 8);
    join
    rom_run();
    unmapped_run();
    fork
      contention_run(0);
      contention_run(1);
    join
    bus_access(0, 1'b0, soc_pkg::SramBase + 8 * SharedWord, 8'h00, '0, rd, err, exp);
    check_val("shared word after contention", exp, rd);
    clint_run();
    // Debug window, then the gate follows req and en
    while (cycle < soc_pkg::DebugDelayCycles - 1) @(negedge clk);
    if (cycle == soc_pkg::DebugDelayCycles - 1) begin
      check_val("debug blocked in window", 64'd0, 64'(debug_out));
    end
    debug_step(1'b1, 1'b1, "debug req and en");
    debug_step(1'b0, 1'b1, "debug no req");
    debug_step(1'b1, 1'b1, "debug req again");
    debug_step(1'b1, 1'b0, "debug disabled");
    $display("Error counts: %0d check errors, %0d assertion failures",
             errors, soc_top_i.i_soc_props.fail_cnt);
    if (errors == 0 && soc_top_i.i_soc_props.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (2000 + TestCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests finished", 2000 + TestCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
